/* Makefile */
TOP = axil_wr_arbiter_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f filelist.f --top-module axil_wr_arbiter

sim:
	rm -f sim.log
	verilator --binary --timing --assert -f filelist.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "TEST OK" sim.log

clean:
	rm -rf obj_dir sim.log

/* arb_pkg.sv */
`include "axil_arb_cfg.svh"

package arb_pkg;

        // manager number and per-manager bit mask
        typedef logic [$clog2(`AXIL_ARB_NUM_MGR)-1:0] mgr_idx_t;
        typedef logic [`AXIL_ARB_NUM_MGR-1:0]         mgr_mask_t;

        // highest manager number, the search after reset starts past it
        localparam mgr_idx_t LAST_MGR = mgr_idx_t'(`AXIL_ARB_NUM_MGR - 1);

        // one write transaction steps through these in order
        typedef enum logic [1:0] {
                PH_IDLE = 2'd0,
                PH_ADDR = 2'd1,
                PH_DATA = 2'd2,
                PH_RESP = 2'd3
        } wr_phase_t;

endpackage

/* axil_arb_cfg.svh */
`ifndef AXIL_ARB_CFG_SVH
`define AXIL_ARB_CFG_SVH

// number of managers sharing the subordinate port
`define AXIL_ARB_NUM_MGR 3

// AXI-lite write address width
`define AXIL_ARB_ADDR_W 32

// write data width, strobe width follows as data/8
`define AXIL_ARB_DATA_W 32

// awprot width, fixed by the AXI spec
`define AXIL_ARB_PROT_W 3

`endif

/* axil_pkg.sv */
`include "axil_arb_cfg.svh"

package axil_pkg;

        // write address channel fields
        typedef logic [`AXIL_ARB_ADDR_W-1:0] addr_t;
        typedef logic [`AXIL_ARB_PROT_W-1:0] prot_t;

        // write data channel fields
        typedef logic [`AXIL_ARB_DATA_W-1:0] data_t;

        // one strobe bit per data byte
        typedef logic [`AXIL_ARB_DATA_W/8-1:0] strb_t;

endpackage

/* axil_wr_arbiter.sv */
`timescale 1ns/100ps
`include "axil_arb_cfg.svh"

module axil_wr_arbiter import axil_pkg::*, arb_pkg::*; (
        input  logic      clk,
        input  logic      i_rst_n,

        // manager write address channels
        input  mgr_mask_t i_m_awvalid,
        output mgr_mask_t o_m_awready,
        input  addr_t     i_m_awaddr [`AXIL_ARB_NUM_MGR],
        input  prot_t     i_m_awprot [`AXIL_ARB_NUM_MGR],

        // manager write data channels
        input  mgr_mask_t i_m_wvalid,
        output mgr_mask_t o_m_wready,
        input  data_t     i_m_wdata  [`AXIL_ARB_NUM_MGR],
        input  strb_t     i_m_wstrb  [`AXIL_ARB_NUM_MGR],

        // manager write response channels
        output mgr_mask_t o_m_bvalid,
        input  mgr_mask_t i_m_bready,

        // subordinate write port
        output logic      o_s_awvalid,
        input  logic      i_s_awready,
        output addr_t     o_s_awaddr,
        output prot_t     o_s_awprot,
        output logic      o_s_wvalid,
        input  logic      i_s_wready,
        output data_t     o_s_wdata,
        output strb_t     o_s_wstrb,
        input  logic      i_s_bvalid,
        output logic      o_s_bready
);

        mgr_idx_t  grant;
        wr_phase_t phase;

        axil_wr_if sub_bus ();

        ////////////////////////////////////////////////////////////////////////////
        // subordinate side of the internal bus to plain ports
        ////////////////////////////////////////////////////////////////////////////

        assign o_s_awvalid     = sub_bus.awvalid;
        assign o_s_awaddr      = sub_bus.awaddr;
        assign o_s_awprot      = sub_bus.awprot;
        assign o_s_wvalid      = sub_bus.wvalid;
        assign o_s_wdata       = sub_bus.wdata;
        assign o_s_wstrb       = sub_bus.wstrb;
        assign o_s_bready      = sub_bus.bready;

        assign sub_bus.awready = i_s_awready;
        assign sub_bus.wready  = i_s_wready;
        assign sub_bus.bvalid  = i_s_bvalid;

        // awvalid doubles as the request line
        wr_grant_ctrl u_grant_ctrl (
                .clk      (clk),
                .i_rst_n  (i_rst_n),
                .i_aw_req (i_m_awvalid),
                .sub_mon  (sub_bus.mon),
                .o_grant  (grant),
                .o_phase  (phase)
        );

        wr_channel_mux u_channel_mux (
                .i_grant     (grant),
                .i_phase     (phase),
                .i_m_awvalid (i_m_awvalid),
                .i_m_wvalid  (i_m_wvalid),
                .i_m_bready  (i_m_bready),
                .i_m_awaddr  (i_m_awaddr),
                .i_m_awprot  (i_m_awprot),
                .i_m_wdata   (i_m_wdata),
                .i_m_wstrb   (i_m_wstrb),
                .o_m_awready (o_m_awready),
                .o_m_wready  (o_m_wready),
                .o_m_bvalid  (o_m_bvalid),
                .sub_bus     (sub_bus.mgr)
        );

endmodule

/* axil_wr_arbiter_properties.sv */
`timescale 1ns/100ps

module axil_wr_arbiter_properties import axil_pkg::*, arb_pkg::*; (
        input logic      clk,
        input logic      i_rst_n,
        input mgr_mask_t o_m_bvalid,
        input logic      o_s_awvalid,
        input logic      i_s_awready,
        input addr_t     o_s_awaddr,
        input logic      o_s_wvalid
);

        // number of assertion failures so far
        int assert_fail_cnt = 0;

        // response goes to one manager at most
        bvalid_onehot: assert property (@(posedge clk) disable iff (!i_rst_n)
                $onehot0(o_m_bvalid))
                else begin
                        assert_fail_cnt++;
                        $error("o_m_bvalid has more than one bit set: %b", o_m_bvalid);
                end

        // stalled address keeps valid and payload
        aw_stable: assert property (@(posedge clk) disable iff (!i_rst_n)
                o_s_awvalid && !i_s_awready |=> o_s_awvalid && $stable(o_s_awaddr))
                else begin
                        assert_fail_cnt++;
                        $error("o_s_awvalid or o_s_awaddr changed before i_s_awready");
                end

        // address and data phases never overlap
        aw_w_exclusive: assert property (@(posedge clk) disable iff (!i_rst_n)
                !(o_s_wvalid && o_s_awvalid))
                else begin
                        assert_fail_cnt++;
                        $error("o_s_wvalid and o_s_awvalid high in the same cycle");
                end

endmodule

bind axil_wr_arbiter axil_wr_arbiter_properties u_properties (
        .clk         (clk),
        .i_rst_n     (i_rst_n),
        .o_m_bvalid  (o_m_bvalid),
        .o_s_awvalid (o_s_awvalid),
        .i_s_awready (i_s_awready),
        .o_s_awaddr  (o_s_awaddr),
        .o_s_wvalid  (o_s_wvalid)
);

/* axil_wr_arbiter_tb.sv */
`timescale 1ns/100ps
`include "axil_arb_cfg.svh"

module axil_wr_arbiter_tb import axil_pkg::*, arb_pkg::*; ();

        localparam int NUM_MGR    = `AXIL_ARB_NUM_MGR;
        localparam int NUM_ROWS   = 11;
        localparam int RST_CYCLES = 16;

        // request mask, ready delay, response delay
        localparam logic [18:0] STIM [NUM_ROWS] = '{
                {3'b001, 8'd1,  8'd1},
                {3'b010, 8'd0,  8'd2},
                {3'b100, 8'd2,  8'd0},
                {3'b011, 8'd1,  8'd1},
                {3'b101, 8'd3,  8'd2},
                {3'b110, 8'd0,  8'd0},
                {3'b111, 8'd1,  8'd1},
                {3'b111, 8'd2,  8'd1},
                {3'b111, 8'd9,  8'd12},
                {3'b011, 8'd12, 8'd7},
                {3'b110, 8'd6,  8'd15}
        };

        logic      clk;
        logic      i_rst_n;
        mgr_mask_t i_m_awvalid;
        mgr_mask_t o_m_awready;
        addr_t     i_m_awaddr [NUM_MGR];
        prot_t     i_m_awprot [NUM_MGR];
        mgr_mask_t i_m_wvalid;
        mgr_mask_t o_m_wready;
        data_t     i_m_wdata  [NUM_MGR];
        strb_t     i_m_wstrb  [NUM_MGR];
        mgr_mask_t o_m_bvalid;
        mgr_mask_t i_m_bready;
        logic      o_s_awvalid;
        logic      i_s_awready;
        addr_t     o_s_awaddr;
        prot_t     o_s_awprot;
        logic      o_s_wvalid;
        logic      i_s_wready;
        data_t     o_s_wdata;
        strb_t     o_s_wstrb;
        logic      i_s_bvalid;
        logic      o_s_bready;

        // manager and subordinate model state
        mgr_mask_t pend;
        mgr_mask_t aw_done;
        mgr_mask_t w_done;
        int        rdy_dly;
        int        resp_dly;
        int        aw_cnt;
        int        w_cnt;
        int        b_cnt;
        logic      b_pend;

        // reference round-robin model
        mgr_idx_t  last_grant;
        mgr_idx_t  exp_q [$];
        logic      exp_aw_seen;

        // values seen at the falling edge and acted on after the next rising edge
        logic      s_awv;
        logic      s_wv;
        logic      aw_fire_s;
        logic      w_fire_s;
        logic      b_fire_s;
        mgr_mask_t m_aw_fire;
        mgr_mask_t m_w_fire;
        mgr_mask_t m_b_fire;
        logic      aw_hold;
        logic      w_hold;
        addr_t     hold_addr;
        prot_t     hold_prot;
        data_t     hold_data;
        strb_t     hold_strb;

        int        err_cnt;
        int        chk_cnt;
        int        assert_errs;
        int        cycle_cnt = 0;
        int        cycle_limit;
        integer    seed;

        axil_wr_arbiter UUT (.*);

        initial begin
                clk = 1'b0;
        end

        always #50 clk = ~clk;

        ////////////////////////////////////////////////////////////////////////////
        // helpers
        ////////////////////////////////////////////////////////////////////////////

        task automatic check_val(input string name, input logic [31:0] got,
                                 input logic [31:0] want);
                chk_cnt++;
                if (got !== want) begin
                        err_cnt++;
                        $display("[FAIL] %s: expected 0x%h, got 0x%h", name, want, got);
                end
        endtask

        // worst case per transaction is two ready waits plus one response wait and overhead
        function automatic int calc_limit();
                int max_rdy;
                int max_resp;
                max_rdy  = 0;
                max_resp = 0;
                for (int r = 0; r < NUM_ROWS; r++) begin
                        if (int'(STIM[r][15:8]) > max_rdy) max_rdy = int'(STIM[r][15:8]);
                        if (int'(STIM[r][7:0]) > max_resp) max_resp = int'(STIM[r][7:0]);
                end
                return RST_CYCLES + 2 + NUM_ROWS * NUM_MGR * (2 * max_rdy + max_resp + 8);
        endfunction

        task automatic check_quiet();
                check_val("o_s_awvalid", o_s_awvalid, 0);
                check_val("o_s_wvalid", o_s_wvalid, 0);
                check_val("o_s_bready", o_s_bready, 0);
                check_val("o_m_awready", o_m_awready, 0);
                check_val("o_m_wready", o_m_wready, 0);
                check_val("o_m_bvalid", o_m_bvalid, 0);
        endtask

        task automatic start_row(input int r);
                mgr_mask_t mask;
                int        start;
                int        cand;
                mask     = STIM[r][18:16];
                rdy_dly  = int'(STIM[r][15:8]);
                resp_dly = int'(STIM[r][7:0]);
                // expected order rotates on from the last grant
                start = int'(last_grant);
                for (int i = 1; i <= NUM_MGR; i++) begin
                        cand = (start + i) % NUM_MGR;
                        if (mask[cand]) begin
                                exp_q.push_back(mgr_idx_t'(cand));
                                last_grant = mgr_idx_t'(cand);
                        end
                end
                for (int m = 0; m < NUM_MGR; m++) begin
                        if (mask[m]) begin
                                i_m_awaddr[m] = $random(seed);
                                i_m_awprot[m] = prot_t'($random(seed));
                                i_m_wdata[m]  = $random(seed);
                                i_m_wstrb[m]  = strb_t'($random(seed));
                        end
                end
                pend        = mask;
                aw_done     = '0;
                w_done      = '0;
                i_m_awvalid = mask;
                i_m_wvalid  = mask;
                i_m_bready  = '0;
                aw_cnt      = 0;
                w_cnt       = 0;
                i_s_awready = (rdy_dly == 0);
                i_s_wready  = (rdy_dly == 0);
        endtask

        task automatic sample_outputs();
                mgr_mask_t exp_oh;
                mgr_idx_t  exp_mgr;
                exp_oh  = '0;
                exp_mgr = '0;
                if (exp_q.size() != 0) begin
                        exp_mgr = exp_q[0];
                        exp_oh  = mgr_mask_t'(1) << exp_mgr;
                end
                // nobody but the expected owner sees a ready or a response
                check_val("o_m_awready", o_m_awready & ~exp_oh, 0);
                check_val("o_m_wready", o_m_wready & ~exp_oh, 0);
                check_val("o_m_bvalid", o_m_bvalid & ~exp_oh, 0);
                check_val("o_s_wvalid & o_s_awvalid", o_s_wvalid & o_s_awvalid, 0);
                // bready only reaches the subordinate while the owner waits for its response
                check_val("o_s_bready", o_s_bready, b_pend & i_m_bready[exp_mgr]);
                // stalled channels keep valid and payload
                if (aw_hold) begin
                        check_val("o_s_awvalid", o_s_awvalid, 1);
                        check_val("o_s_awaddr", o_s_awaddr, hold_addr);
                        check_val("o_s_awprot", o_s_awprot, hold_prot);
                end
                if (w_hold) begin
                        check_val("o_s_wvalid", o_s_wvalid, 1);
                        check_val("o_s_wdata", o_s_wdata, hold_data);
                        check_val("o_s_wstrb", o_s_wstrb, hold_strb);
                end
                s_awv     = o_s_awvalid;
                s_wv      = o_s_wvalid;
                aw_fire_s = o_s_awvalid & i_s_awready;
                w_fire_s  = o_s_wvalid & i_s_wready;
                b_fire_s  = i_s_bvalid & o_s_bready;
                m_aw_fire = i_m_awvalid & o_m_awready;
                m_w_fire  = i_m_wvalid & o_m_wready;
                m_b_fire  = o_m_bvalid & i_m_bready;
                aw_hold   = o_s_awvalid & ~i_s_awready;
                w_hold    = o_s_wvalid & ~i_s_wready;
                hold_addr = o_s_awaddr;
                hold_prot = o_s_awprot;
                hold_data = o_s_wdata;
                hold_strb = o_s_wstrb;
                if (aw_fire_s) begin
                        check_val("o_s_awaddr", o_s_awaddr, i_m_awaddr[exp_mgr]);
                        check_val("o_s_awprot", o_s_awprot, i_m_awprot[exp_mgr]);
                        check_val("o_m_awready", o_m_awready, exp_oh);
                        exp_aw_seen = 1'b1;
                end
                if (w_fire_s) begin
                        check_val("address before data", exp_aw_seen, 1);
                        check_val("o_s_wdata", o_s_wdata, i_m_wdata[exp_mgr]);
                        check_val("o_s_wstrb", o_s_wstrb, i_m_wstrb[exp_mgr]);
                        check_val("o_m_wready", o_m_wready, exp_oh);
                end
                if (i_s_bvalid) begin
                        check_val("o_m_bvalid", o_m_bvalid, exp_oh);
                end
                if (b_fire_s) begin
                        if (exp_q.size() != 0) begin
                                void'(exp_q.pop_front());
                        end
                        exp_aw_seen = 1'b0;
                end
        endtask

        task automatic update_models();
                for (int m = 0; m < NUM_MGR; m++) begin
                        if (m_aw_fire[m]) aw_done[m] = 1'b1;
                        if (m_w_fire[m]) w_done[m] = 1'b1;
                        if (m_b_fire[m]) pend[m] = 1'b0;
                end
                i_m_awvalid = pend & ~aw_done;
                i_m_wvalid  = pend & ~w_done;
                // a manager takes its response once its data has gone
                i_m_bready  = pend & w_done;
                // subordinate readies come rdy_dly cycles into a valid
                if (aw_fire_s) begin
                        aw_cnt      = 0;
                        i_s_awready = (rdy_dly == 0);
                end else if (s_awv) begin
                        aw_cnt++;
                        i_s_awready = (aw_cnt >= rdy_dly);
                end
                if (w_fire_s) begin
                        w_cnt      = 0;
                        i_s_wready = (rdy_dly == 0);
                end else if (s_wv) begin
                        w_cnt++;
                        i_s_wready = (w_cnt >= rdy_dly);
                end
                // response follows the data transfer after resp_dly cycles
                if (b_fire_s) begin
                        i_s_bvalid = 1'b0;
                        b_pend     = 1'b0;
                end else if (w_fire_s) begin
                        b_pend     = 1'b1;
                        b_cnt      = 0;
                        i_s_bvalid = (resp_dly == 0);
                end else if (b_pend && !i_s_bvalid) begin
                        b_cnt++;
                        i_s_bvalid = (b_cnt >= resp_dly);
                end
        endtask

        ////////////////////////////////////////////////////////////////////////////
        // run limit
        ////////////////////////////////////////////////////////////////////////////

        always @(posedge clk) begin
                cycle_cnt <= cycle_cnt + 1;
                if (cycle_cnt >= cycle_limit) begin
                        $display("timeout: transactions still pending after %0d cycles",
                                 cycle_limit);
                        $display("TEST FAILED");
                        $finish;
                end
        end

        ////////////////////////////////////////////////////////////////////////////
        // main sequence
        ////////////////////////////////////////////////////////////////////////////

        initial begin
                seed        = 32'he819_b6d2;
                err_cnt     = 0;
                chk_cnt     = 0;
                assert_errs = 0;
                cycle_limit = calc_limit();
                last_grant  = LAST_MGR;
                exp_aw_seen = 1'b0;
                aw_hold     = 1'b0;
                w_hold      = 1'b0;
                b_pend      = 1'b0;
                pend        = '0;
                aw_done     = '0;
                w_done      = '0;
                for (int m = 0; m < NUM_MGR; m++) begin
                        i_m_awaddr[m] = '0;
                        i_m_awprot[m] = '0;
                        i_m_wdata[m]  = '0;
                        i_m_wstrb[m]  = '0;
                end
                // requests and readies up during reset must not leak through
                i_rst_n     = 1'b0;
                i_m_awvalid = '1;
                i_m_wvalid  = '1;
                i_m_bready  = '1;
                i_s_awready = 1'b1;
                i_s_wready  = 1'b1;
                i_s_bvalid  = 1'b1;
                for (int i = 0; i < RST_CYCLES; i++) begin
                        @(posedge clk);
                        if (i < RST_CYCLES - 1) begin
                                @(negedge clk);
                                check_quiet();
                        end
                end
                #1;
                i_rst_n     = 1'b1;
                i_m_awvalid = '0;
                i_m_wvalid  = '0;
                i_m_bready  = '0;
                i_s_awready = 1'b0;
                i_s_wready  = 1'b0;
                i_s_bvalid  = 1'b0;
                @(negedge clk);
                check_quiet();
                @(posedge clk);
                #1;
                for (int r = 0; r < NUM_ROWS; r++) begin
                        start_row(r);
                        while (pend != '0) begin
                                @(negedge clk);
                                sample_outputs();
                                @(posedge clk);
                                #1;
                                update_models();
                        end
                        check_val("expected grants left", exp_q.size(), 0);
                end
                assert_errs = UUT.u_properties.assert_fail_cnt;
                $display("checks: %0d  errors: %0d  assertion failures: %0d",
                         chk_cnt, err_cnt, assert_errs);
                if (err_cnt == 0 && assert_errs == 0) begin
                        $display("TEST OK");
                end else begin
                        $display("TEST FAILED");
                end
                $finish;
        end

endmodule

/* axil_wr_if.sv */
`timescale 1ns/100ps

interface axil_wr_if import axil_pkg::*; ();

        // write address channel
        logic  awvalid;
        logic  awready;
        addr_t awaddr;
        prot_t awprot;

        // write data channel
        logic  wvalid;
        logic  wready;
        data_t wdata;
        strb_t wstrb;

        // write response channel, resp code not carried
        logic  bvalid;
        logic  bready;

        modport mgr (
                output awvalid, awaddr, awprot,
                output wvalid, wdata, wstrb,
                output bready,
                input  awready, wready, bvalid
        );

        modport sub (
                input  awvalid, awaddr, awprot,
                input  wvalid, wdata, wstrb,
                input  bready,
                output awready, wready, bvalid
        );

        modport mon (
                input awvalid, awready, awaddr, awprot,
                input wvalid, wready, wdata, wstrb,
                input bvalid, bready
        );

endinterface

/* filelist.f */
+incdir+.
axil_pkg.sv
arb_pkg.sv
axil_wr_if.sv
wr_grant_ctrl.sv
wr_channel_mux.sv
axil_wr_arbiter.sv
axil_wr_arbiter_properties.sv
axil_wr_arbiter_tb.sv

/* wr_channel_mux.sv */
`timescale 1ns/100ps
`include "axil_arb_cfg.svh"

module wr_channel_mux import axil_pkg::*, arb_pkg::*; (
        input  mgr_idx_t  i_grant,
        input  wr_phase_t i_phase,

        // manager side valids and bready
        input  mgr_mask_t i_m_awvalid,
        input  mgr_mask_t i_m_wvalid,
        input  mgr_mask_t i_m_bready,

        // manager side payloads
        input  addr_t     i_m_awaddr [`AXIL_ARB_NUM_MGR],
        input  prot_t     i_m_awprot [`AXIL_ARB_NUM_MGR],
        input  data_t     i_m_wdata  [`AXIL_ARB_NUM_MGR],
        input  strb_t     i_m_wstrb  [`AXIL_ARB_NUM_MGR],

        // returned to the granted manager only
        output mgr_mask_t o_m_awready,
        output mgr_mask_t o_m_wready,
        output mgr_mask_t o_m_bvalid,

        // toward the subordinate
        axil_wr_if.mgr    sub_bus
);

        logic      in_addr;
        logic      in_data;
        logic      in_resp;
        mgr_mask_t grant_oh;

        logic      aw_ready_g;
        logic      w_ready_g;
        logic      b_valid_g;

        // phase decode
        assign in_addr = (i_phase == PH_ADDR);
        assign in_data = (i_phase == PH_DATA);
        assign in_resp = (i_phase == PH_RESP);

        // one-hot of the granted manager for the return path
        assign grant_oh = mgr_mask_t'(1) << i_grant;

        ////////////////////////////////////////////////////////////////////////////
        // forward path, granted manager onto the subordinate
        ////////////////////////////////////////////////////////////////////////////

        // valids only open in their own phase
        assign sub_bus.awvalid = in_addr & i_m_awvalid[i_grant];
        assign sub_bus.wvalid  = in_data & i_m_wvalid[i_grant];
        assign sub_bus.bready  = in_resp & i_m_bready[i_grant];

        // payloads follow the grant, qualified by the valids above
        assign sub_bus.awaddr  = i_m_awaddr[i_grant];
        assign sub_bus.awprot  = i_m_awprot[i_grant];
        assign sub_bus.wdata   = i_m_wdata[i_grant];
        assign sub_bus.wstrb   = i_m_wstrb[i_grant];

        ////////////////////////////////////////////////////////////////////////////
        // return path, ready and bvalid back to the owner
        ////////////////////////////////////////////////////////////////////////////

        assign aw_ready_g = in_addr & sub_bus.awready;
        assign w_ready_g  = in_data & sub_bus.wready;
        assign b_valid_g  = in_resp & sub_bus.bvalid;

        // every other manager sees zeros
        assign o_m_awready = grant_oh & {`AXIL_ARB_NUM_MGR{aw_ready_g}};
        assign o_m_wready  = grant_oh & {`AXIL_ARB_NUM_MGR{w_ready_g}};
        assign o_m_bvalid  = grant_oh & {`AXIL_ARB_NUM_MGR{b_valid_g}};

endmodule

/* wr_grant_ctrl.sv */
`timescale 1ns/100ps
`include "axil_arb_cfg.svh"

module wr_grant_ctrl import arb_pkg::*; (
        input  logic      clk,
        input  logic      i_rst_n,

        // awvalid of every manager, used as its request
        input  mgr_mask_t i_aw_req,

        // subordinate side, watched for the three transfers
        axil_wr_if.mon    sub_mon,

        output mgr_idx_t  o_grant,
        output wr_phase_t o_phase
);

        // grant_q keeps its value after the response, so it is also the last-granted
        mgr_idx_t  grant_q;
        mgr_idx_t  next_grant;
        mgr_idx_t  cand;
        logic      req_found;

        wr_phase_t phase_q;
        wr_phase_t phase_d;

        logic      aw_fire;
        logic      w_fire;
        logic      b_fire;

        ////////////////////////////////////////////////////////////////////////////
        // handshakes on the subordinate port
        ////////////////////////////////////////////////////////////////////////////

        // the mux gates the valids by phase, so each fire only shows in its phase
        assign aw_fire = sub_mon.awvalid & sub_mon.awready;
        assign w_fire  = sub_mon.wvalid & sub_mon.wready;
        assign b_fire  = sub_mon.bvalid & sub_mon.bready;

        ////////////////////////////////////////////////////////////////////////////
        // round-robin pick
        ////////////////////////////////////////////////////////////////////////////

        // start one past the last grant, wrap, first requester wins
        always_comb begin
                next_grant = grant_q;
                req_found  = 1'b0;
                cand       = grant_q;
                for (int i = 1; i <= `AXIL_ARB_NUM_MGR; i++) begin
                        cand = mgr_idx_t'((int'(grant_q) + i) % `AXIL_ARB_NUM_MGR);
                        if (!req_found && i_aw_req[cand]) begin
                                next_grant = cand;
                                req_found  = 1'b1;
                        end
                end
        end

        ////////////////////////////////////////////////////////////////////////////
        // phase FSM
        ////////////////////////////////////////////////////////////////////////////

        always_comb begin
                phase_d = phase_q;
                case (phase_q)
                        PH_IDLE: begin
                                if (req_found) begin
                                        phase_d = PH_ADDR;
                                end
                        end
                        PH_ADDR: begin
                                if (aw_fire) begin
                                        phase_d = PH_DATA;
                                end
                        end
                        PH_DATA: begin
                                if (w_fire) begin
                                        phase_d = PH_RESP;
                                end
                        end
                        PH_RESP: begin
                                // transaction ends on the granted manager's bready
                                if (b_fire) begin
                                        phase_d = PH_IDLE;
                                end
                        end
                        default: begin
                                phase_d = PH_IDLE;
                        end
                endcase
        end

        always_ff @(posedge clk) begin
                if (!i_rst_n) begin
                        phase_q <= PH_IDLE;
                        // manager 0 wins first after reset
                        grant_q <= LAST_MGR;
                end else begin
                        phase_q <= phase_d;
                        if (phase_q == PH_IDLE && req_found) begin
                                grant_q <= next_grant;
                        end
                end
        end

        assign o_grant = grant_q;
        assign o_phase = phase_q;

endmodule
